//--- source/loader_pkg.sv
/*
 * Media loader shared definitions
 * Memory map of the loader, file kinds decoded from the host index,
 * and the packed structs passed between the loader stages.
 */
`default_nettype none

package loader_pkg;

	// ====================
	// Memory map
	// ====================
	localparam int MEM_AW = 25;
	localparam logic [MEM_AW-1:0] CRT_BASE = 25'h100000;
	localparam logic [MEM_AW-1:0] TAP_BASE = 25'h200000;
	localparam logic [15:0] RAM_LAST = 16'hFFFF;

	// Cartridge file layout
	localparam logic [MEM_AW-1:0] CRT_ID_OFS = 25'h16;
	localparam logic [MEM_AW-1:0] CRT_CHIP_OFS = 25'h40;
	localparam int CRT_ALIGN_BITS = 13;
	localparam logic [MEM_AW-1:0] CRT_ALIGN_MASK = (MEM_AW'(1) << CRT_ALIGN_BITS) - 1'b1;
	localparam int CHIP_HDR_BYTES = 16;

	// Page-zero pointer writes after a program load
	localparam int PTR_COUNT = 12;

	typedef enum logic [1:0] {
		KIND_NONE,
		KIND_PRG,
		KIND_CRT,
		KIND_TAP
	} load_kind_e;

	// ====================
	// Stage payloads
	// ====================
	typedef struct packed {
		logic [7:0] index;
		logic [MEM_AW-1:0] offset;
		logic [7:0] data;
	} dl_beat_t;

	typedef struct packed {
		logic [MEM_AW-1:0] addr;
		logic [7:0] data;
	} mem_wr_t;

	// End address is start plus the number of data bytes
	typedef struct packed {
		logic [15:0] start_addr;
		logic [15:0] end_addr;
	} prg_span_t;

	typedef struct packed {
		logic [15:0] id;
		logic [7:0] exrom;
		logic [7:0] game;
	} cart_info_t;

	typedef struct packed {
		logic [7:0] bank_type;
		logic [15:0] bank_num;
		logic [15:0] load_addr;
		logic [15:0] size;
		logic [MEM_AW-1:0] mem_addr;
	} crt_bank_t;

	// Host index to file kind
	function automatic load_kind_e kind_of(input logic [7:0] index);
		case (index)
			8'h04: kind_of = KIND_PRG;
			8'h05, 8'hC0: kind_of = KIND_CRT;
			8'h06: kind_of = KIND_TAP;
			default: kind_of = KIND_NONE;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- source/load_decoder.sv
/*
 * Download stream decoder
 * Classifies each host byte by file kind, keeps the load address and
 * turns payload bytes into addressed memory writes. Parses cartridge
 * headers and chip packets, and flags the end of a program file.
 */
`timescale 1ns/1ps
`default_nettype none

module load_decoder (
	input wire clk_sys,
	input wire reset_n,
	input wire loader_pkg::dl_beat_t dl_beat_i,
	input wire dl_valid_i,
	output logic dl_ready_o,
	input wire dl_active_i,
	output loader_pkg::mem_wr_t wr_o,
	output logic wr_valid_o,
	input wire wr_ready_i,
	output logic prg_done_o,
	output loader_pkg::prg_span_t prg_span_o,
	output loader_pkg::cart_info_t cart_info_o,
	output loader_pkg::crt_bank_t crt_bank_o,
	output logic crt_bank_valid_o
);

	typedef enum logic {
		CHIP_HEADER,
		CHIP_DATA
	} chip_state_e;

	loader_pkg::load_kind_e beat_kind, kind_q;
	chip_state_e chip_state_q;
	loader_pkg::mem_wr_t wr_q;
	loader_pkg::prg_span_t span_q;
	loader_pkg::cart_info_t cart_q;
	loader_pkg::crt_bank_t bank_q;
	logic [loader_pkg::MEM_AW-1:0] load_addr_q, emit_addr, aligned_addr;
	logic [31:0] chip_len_q;
	logic [3:0] hdr_cnt_q;
	logic run_q, wr_valid_q, bank_valid_q, prg_done_q, done_pend_q, active_q;
	logic take, emit, out_free, file_end, end_seen, in_chips, hdr_last;

	assign out_free = !wr_valid_q || wr_ready_i;
	assign dl_ready_o = run_q && out_free;
	assign take = dl_valid_i && dl_ready_o;
	assign file_end = active_q && !dl_active_i;
	assign end_seen = file_end || done_pend_q;
	assign in_chips = dl_beat_i.offset >= loader_pkg::CRT_CHIP_OFS;
	assign hdr_last = hdr_cnt_q == 4'(loader_pkg::CHIP_HDR_BYTES - 1);

	// Next chip starts on an 8 KB boundary
	assign aligned_addr = (load_addr_q + loader_pkg::CRT_ALIGN_MASK) & ~loader_pkg::CRT_ALIGN_MASK;

	always_comb begin
		beat_kind = loader_pkg::kind_of(dl_beat_i.index);
		emit = 1'b0;
		emit_addr = load_addr_q;
		case (beat_kind)
			loader_pkg::KIND_PRG: emit = dl_beat_i.offset > 25'd1;
			loader_pkg::KIND_CRT: emit = in_chips && chip_state_q == CHIP_DATA;
			loader_pkg::KIND_TAP: begin
				emit = 1'b1;
				emit_addr = loader_pkg::TAP_BASE + dl_beat_i.offset;
			end
			default: emit = 1'b0;
		endcase
	end

	// ====================
	// Control state
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			run_q <= 1'b0;
			wr_valid_q <= 1'b0;
			kind_q <= loader_pkg::KIND_NONE;
			chip_state_q <= CHIP_HEADER;
			hdr_cnt_q <= '0;
			bank_valid_q <= 1'b0;
			prg_done_q <= 1'b0;
			done_pend_q <= 1'b0;
			active_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			active_q <= dl_active_i;
			bank_valid_q <= 1'b0;
			prg_done_q <= 1'b0;
			if (take && emit)
				wr_valid_q <= 1'b1;
			else if (wr_ready_i)
				wr_valid_q <= 1'b0;
			if (take) begin
				kind_q <= beat_kind;
				if (beat_kind == loader_pkg::KIND_CRT) begin
					if (dl_beat_i.offset == '0) begin
						chip_state_q <= CHIP_HEADER;
						hdr_cnt_q <= '0;
					end else if (in_chips && chip_state_q == CHIP_HEADER) begin
						hdr_cnt_q <= hdr_cnt_q + 1'b1;
						if (hdr_last) begin
							bank_valid_q <= 1'b1;
							// A chip without payload is followed by the next header
							if (chip_len_q != 32'(loader_pkg::CHIP_HDR_BYTES))
								chip_state_q <= CHIP_DATA;
						end
					end else if (in_chips && chip_len_q == 32'd1) begin
						chip_state_q <= CHIP_HEADER;
					end
				end
			end
			// Program end waits until the last write has left
			if (end_seen) begin
				if (out_free && !take) begin
					prg_done_q <= kind_q == loader_pkg::KIND_PRG;
					done_pend_q <= 1'b0;
				end else begin
					done_pend_q <= 1'b1;
				end
			end
		end
	end

	// ====================
	// Payload and addresses
	// ====================
	always_ff @(posedge clk_sys) begin
		if (take) begin
			if (emit) begin
				wr_q.addr <= emit_addr;
				wr_q.data <= dl_beat_i.data;
			end
			if (beat_kind == loader_pkg::KIND_PRG) begin
				if (dl_beat_i.offset == 25'd0) begin
					load_addr_q <= loader_pkg::MEM_AW'(dl_beat_i.data);
					span_q.start_addr[7:0] <= dl_beat_i.data;
					span_q.end_addr[7:0] <= dl_beat_i.data;
				end else if (dl_beat_i.offset == 25'd1) begin
					load_addr_q[15:8] <= dl_beat_i.data;
					span_q.start_addr[15:8] <= dl_beat_i.data;
					span_q.end_addr[15:8] <= dl_beat_i.data;
				end else begin
					load_addr_q <= load_addr_q + 1'b1;
					span_q.end_addr <= span_q.end_addr + 1'b1;
				end
			end
			if (beat_kind == loader_pkg::KIND_CRT) begin
				if (dl_beat_i.offset == 25'd0)
					load_addr_q <= loader_pkg::CRT_BASE;
				if (dl_beat_i.offset == loader_pkg::CRT_ID_OFS)
					cart_q.id[15:8] <= dl_beat_i.data;
				if (dl_beat_i.offset == loader_pkg::CRT_ID_OFS + 25'd1)
					cart_q.id[7:0] <= dl_beat_i.data;
				if (dl_beat_i.offset == loader_pkg::CRT_ID_OFS + 25'd2)
					cart_q.exrom <= dl_beat_i.data;
				if (dl_beat_i.offset == loader_pkg::CRT_ID_OFS + 25'd3)
					cart_q.game <= dl_beat_i.data;
				if (in_chips && chip_state_q == CHIP_HEADER) begin
					case (hdr_cnt_q)
						4'd0: begin
							load_addr_q <= aligned_addr;
							bank_q.mem_addr <= aligned_addr;
						end
						// Packet length is big-endian
						4'd4, 4'd5, 4'd6, 4'd7: chip_len_q <= {chip_len_q[23:0], dl_beat_i.data};
						4'd9: bank_q.bank_type <= dl_beat_i.data;
						4'd10: bank_q.bank_num[15:8] <= dl_beat_i.data;
						4'd11: bank_q.bank_num[7:0] <= dl_beat_i.data;
						4'd12: bank_q.load_addr[15:8] <= dl_beat_i.data;
						4'd13: bank_q.load_addr[7:0] <= dl_beat_i.data;
						4'd14: bank_q.size[15:8] <= dl_beat_i.data;
						4'd15: begin
							bank_q.size[7:0] <= dl_beat_i.data;
							chip_len_q <= chip_len_q - 32'(loader_pkg::CHIP_HDR_BYTES);
						end
						default: ;
					endcase
				end else if (in_chips) begin
					load_addr_q <= load_addr_q + 1'b1;
					chip_len_q <= chip_len_q - 1'b1;
				end
			end
		end
	end

	assign wr_o = wr_q;
	assign wr_valid_o = wr_valid_q;
	assign prg_done_o = prg_done_q;
	assign prg_span_o = span_q;
	assign cart_info_o = cart_q;
	assign crt_bank_o = bank_q;
	assign crt_bank_valid_o = bank_valid_q;

	// A write offered downstream is held until taken
	assert property (@(posedge clk_sys) disable iff (!reset_n)
		wr_valid_o && !wr_ready_i |=> wr_valid_o && $stable(wr_o));

endmodule

`default_nettype wire

//--- source/basic_ptr_init.sv
/*
 * Interpreter pointer setup
 * Passes load writes through one register stage. After a program file
 * it appends the twelve page-zero pointer writes (text, variables,
 * arrays, strings, save start and load end).
 */
`timescale 1ns/1ps
`default_nettype none

module basic_ptr_init (
	input wire clk_sys,
	input wire reset_n,
	input wire loader_pkg::mem_wr_t wr_i,
	input wire wr_valid_i,
	output logic wr_ready_o,
	input wire prg_done_i,
	input wire loader_pkg::prg_span_t prg_span_i,
	output loader_pkg::mem_wr_t wr_o,
	output logic wr_valid_o,
	input wire wr_ready_i
);

	typedef enum logic {
		PTR_IDLE,
		PTR_EMIT
	} ptr_state_e;

	ptr_state_e state_q;
	logic [3:0] ptr_idx_q;
	loader_pkg::prg_span_t span_q;
	loader_pkg::mem_wr_t out_q, ptr_wr;
	logic out_valid_q, out_free, take, ptr_load;
	logic [15:0] ptr_word;

	assign out_free = !out_valid_q || wr_ready_i;
	assign wr_ready_o = state_q == PTR_IDLE && !prg_done_i && out_free;
	assign take = wr_valid_i && wr_ready_o;
	assign ptr_load = state_q == PTR_EMIT && out_free;

	// ====================
	// Pointer table
	// ====================
	// Entries 0..7 sit at 2B..32, entries 8..11 at AC..AF
	// Entries 0, 1, 8 and 9 carry the start address, the rest the end
	always_comb begin
		ptr_wr.addr = '0;
		if (ptr_idx_q[3])
			ptr_wr.addr[7:0] = 8'hAC + 8'(ptr_idx_q[1:0]);
		else
			ptr_wr.addr[7:0] = 8'h2B + 8'(ptr_idx_q[2:0]);
		ptr_word = (ptr_idx_q[2:1] == 2'b00) ? span_q.start_addr : span_q.end_addr;
		ptr_wr.data = ptr_idx_q[0] ? ptr_word[15:8] : ptr_word[7:0];
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state_q <= PTR_IDLE;
			ptr_idx_q <= '0;
			out_valid_q <= 1'b0;
		end else begin
			if (take || ptr_load)
				out_valid_q <= 1'b1;
			else if (wr_ready_i)
				out_valid_q <= 1'b0;
			case (state_q)
				PTR_IDLE: begin
					if (prg_done_i) begin
						state_q <= PTR_EMIT;
						ptr_idx_q <= '0;
					end
				end
				PTR_EMIT: begin
					if (ptr_load) begin
						ptr_idx_q <= ptr_idx_q + 1'b1;
						if (ptr_idx_q == 4'(loader_pkg::PTR_COUNT - 1))
							state_q <= PTR_IDLE;
					end
				end
				default: state_q <= PTR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (prg_done_i)
			span_q <= prg_span_i;
		if (take)
			out_q <= wr_i;
		else if (ptr_load)
			out_q <= ptr_wr;
	end

	assign wr_o = out_q;
	assign wr_valid_o = out_valid_q;

endmodule

`default_nettype wire

//--- source/ram_erase_seq.sv
/*
 * System RAM erase sequencer
 * Fills the 64 KB system RAM with the power-on pattern, where every
 * byte repeats bit 6 of its own address.
 */
`timescale 1ns/1ps
`default_nettype none

module ram_erase_seq (
	input wire clk_sys,
	input wire reset_n,
	input wire erase_start_i,
	output logic erase_busy_o,
	output loader_pkg::mem_wr_t wr_o,
	output logic wr_valid_o,
	input wire wr_ready_i
);

	logic busy_q;
	logic [15:0] addr_q;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			busy_q <= 1'b0;
			addr_q <= '0;
		end else if (!busy_q) begin
			// Start pulses during a fill are ignored
			if (erase_start_i) begin
				busy_q <= 1'b1;
				addr_q <= '0;
			end
		end else if (wr_ready_i) begin
			if (addr_q == loader_pkg::RAM_LAST)
				busy_q <= 1'b0;
			else
				addr_q <= addr_q + 1'b1;
		end
	end

	// Fill pattern
	assign wr_o.addr = loader_pkg::MEM_AW'(addr_q);
	assign wr_o.data = {8{addr_q[6]}};
	assign wr_valid_o = busy_q;
	assign erase_busy_o = busy_q;

endmodule

`default_nettype wire

//--- source/slot_writer.sv
/*
 * Memory slot writer
 * Holds one pending write, taken from the erase input first and from
 * the load path otherwise, and issues it in the next free memory slot.
 */
`timescale 1ns/1ps
`default_nettype none

module slot_writer (
	input wire clk_sys,
	input wire reset_n,
	input wire loader_pkg::mem_wr_t erase_wr_i,
	input wire erase_valid_i,
	output logic erase_ready_o,
	input wire loader_pkg::mem_wr_t load_wr_i,
	input wire load_valid_i,
	output logic load_ready_o,
	input wire slot_i,
	output logic mem_we_o,
	output logic [loader_pkg::MEM_AW-1:0] mem_addr_o,
	output logic [7:0] mem_data_o
);

	loader_pkg::mem_wr_t pend_q;
	logic pend_valid_q;
	logic can_take, take_erase, take_load;

	// The holding register frees up in the slot that drains it
	assign can_take = !pend_valid_q || slot_i;
	assign erase_ready_o = can_take;
	assign load_ready_o = can_take && !erase_valid_i;
	assign take_erase = erase_valid_i && erase_ready_o;
	assign take_load = load_valid_i && load_ready_o;

	always_ff @(posedge clk_sys) begin
		if (!reset_n)
			pend_valid_q <= 1'b0;
		else if (take_erase || take_load)
			pend_valid_q <= 1'b1;
		else if (slot_i)
			pend_valid_q <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (take_erase)
			pend_q <= erase_wr_i;
		else if (take_load)
			pend_q <= load_wr_i;
	end

	// ====================
	// Memory port
	// ====================
	assign mem_we_o = pend_valid_q && slot_i;
	assign mem_addr_o = pend_q.addr;
	assign mem_data_o = pend_q.data;

	// A load write that waits behind erase or a busy slot stays unchanged
	assert property (@(posedge clk_sys) disable iff (!reset_n)
		load_valid_i && !load_ready_o |=> load_valid_i && $stable(load_wr_i));

endmodule

`default_nettype wire

//--- source/media_loader_top.sv
/*
 * Media loader top level
 * Decoder, pointer setup, erase sequencer and slot writer.
 */
`timescale 1ns/1ps
`default_nettype none

module media_loader_top (
	input wire clk_sys,
	input wire reset_n,
	input wire loader_pkg::dl_beat_t dl_beat_i,
	input wire dl_valid_i,
	output logic dl_ready_o,
	input wire dl_active_i,
	input wire erase_start_i,
	output logic erase_busy_o,
	input wire slot_i,
	output logic mem_we_o,
	output logic [loader_pkg::MEM_AW-1:0] mem_addr_o,
	output logic [7:0] mem_data_o,
	output loader_pkg::cart_info_t cart_info_o,
	output loader_pkg::crt_bank_t crt_bank_o,
	output logic crt_bank_valid_o
);

	loader_pkg::mem_wr_t dec_wr, ptr_wr, erase_wr;
	loader_pkg::prg_span_t prg_span;
	logic dec_valid, dec_ready, ptr_valid, ptr_ready, erase_valid, erase_ready;
	logic prg_done;

	load_decoder load_decoder_i (
		.clk_sys(clk_sys), .reset_n(reset_n),
		.dl_beat_i(dl_beat_i), .dl_valid_i(dl_valid_i), .dl_ready_o(dl_ready_o),
		.dl_active_i(dl_active_i),
		.wr_o(dec_wr), .wr_valid_o(dec_valid), .wr_ready_i(dec_ready),
		.prg_done_o(prg_done), .prg_span_o(prg_span), .cart_info_o(cart_info_o),
		.crt_bank_o(crt_bank_o), .crt_bank_valid_o(crt_bank_valid_o)
	);

	basic_ptr_init basic_ptr_init_i (
		.clk_sys(clk_sys), .reset_n(reset_n),
		.wr_i(dec_wr), .wr_valid_i(dec_valid), .wr_ready_o(dec_ready),
		.prg_done_i(prg_done), .prg_span_i(prg_span),
		.wr_o(ptr_wr), .wr_valid_o(ptr_valid), .wr_ready_i(ptr_ready)
	);

	ram_erase_seq ram_erase_seq_i (
		.clk_sys(clk_sys), .reset_n(reset_n),
		.erase_start_i(erase_start_i), .erase_busy_o(erase_busy_o),
		.wr_o(erase_wr), .wr_valid_o(erase_valid), .wr_ready_i(erase_ready)
	);

	slot_writer slot_writer_i (
		.clk_sys(clk_sys), .reset_n(reset_n),
		.erase_wr_i(erase_wr), .erase_valid_i(erase_valid), .erase_ready_o(erase_ready),
		.load_wr_i(ptr_wr), .load_valid_i(ptr_valid), .load_ready_o(ptr_ready),
		.slot_i(slot_i), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
		.mem_data_o(mem_data_o)
	);

endmodule

`default_nettype wire

//--- test/tb_media_loader.sv
/*
 * Media loader testbench
 * Streams program, cartridge and tape files into the loader, runs the
 * RAM erase, and checks the written memory and the chip descriptors.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_media_loader;

	localparam int WAIT_LIMIT = 100000;

	typedef struct packed {
		loader_pkg::load_kind_e kind;
		logic [15:0] addr;
		logic [15:0] len;
		logic [1:0] chips;
		logic [7:0] slot_pct;
		logic erase;
	} test_case_t;

	logic clk_sys = 1'b0;
	logic reset_n;
	loader_pkg::dl_beat_t dl_beat;
	logic dl_valid, dl_ready, dl_active, erase_start, erase_busy;
	logic slot = 1'b0;
	logic mem_we, crt_bank_valid;
	logic [loader_pkg::MEM_AW-1:0] mem_addr;
	logic [7:0] mem_data;
	loader_pkg::cart_info_t cart_info;
	loader_pkg::crt_bank_t crt_bank;

	logic [7:0] mem_model [int unsigned];
	logic [7:0] exp_mem [int unsigned];
	logic [7:0] file_q [$];
	loader_pkg::crt_bank_t bank_seen [$];
	loader_pkg::crt_bank_t bank_exp [$];
	test_case_t case_q [$];
	int unsigned wr_count, stall_count;
	int errors = 0;
	int slot_pct = 100;
	int seed = 16790;
	int unsigned rnd;
	logic stim_started = 1'b0;
	logic timed_out = 1'b0;

	always #50 clk_sys = ~clk_sys;

	media_loader_top media_loader_top_i (
		.clk_sys(clk_sys), .reset_n(reset_n),
		.dl_beat_i(dl_beat), .dl_valid_i(dl_valid), .dl_ready_o(dl_ready),
		.dl_active_i(dl_active),
		.erase_start_i(erase_start), .erase_busy_o(erase_busy),
		.slot_i(slot), .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_data_o(mem_data),
		.cart_info_o(cart_info), .crt_bank_o(crt_bank), .crt_bank_valid_o(crt_bank_valid)
	);

	// Free memory slots at the density of the running case
	task automatic drive_slots();
		forever begin
			@(negedge clk_sys);
			slot = ($urandom % 100) < slot_pct;
		end
	endtask

	// ====================
	// Memory model and scoreboard
	// ====================
	always @(posedge clk_sys) begin
		if (reset_n) begin
			if (mem_we) begin
				mem_model[mem_addr] = mem_data;
				wr_count++;
			end
			if (crt_bank_valid)
				bank_seen.push_back(crt_bank);
			if (dl_valid && !dl_ready)
				stall_count++;
			if (!stim_started && (mem_we || crt_bank_valid)) begin
				$display("Memory write or descriptor strobe seen before any stimulus");
				errors++;
			end
		end
	end

	function automatic logic [7:0] host_index(input loader_pkg::load_kind_e kind);
		case (kind)
			loader_pkg::KIND_PRG: host_index = 8'h04;
			loader_pkg::KIND_CRT: host_index = 8'hC0;
			loader_pkg::KIND_TAP: host_index = 8'h06;
			default: host_index = 8'hFF;
		endcase
	endfunction

	function automatic string kind_text(input loader_pkg::load_kind_e kind);
		case (kind)
			loader_pkg::KIND_PRG: kind_text = "program";
			loader_pkg::KIND_CRT: kind_text = "cartridge";
			loader_pkg::KIND_TAP: kind_text = "tape";
			default: kind_text = "none";
		endcase
	endfunction

	task automatic add_case(input loader_pkg::load_kind_e kind, input logic [15:0] addr,
		input logic [15:0] len, input logic [1:0] chips, input logic [7:0] pct,
		input logic erase);
		test_case_t tc;
		tc.kind = kind;
		tc.addr = addr;
		tc.len = len;
		tc.chips = chips;
		tc.slot_pct = pct;
		tc.erase = erase;
		case_q.push_back(tc);
	endtask

	// Big-endian, as in the cartridge chip packet
	task automatic push_bytes(input logic [31:0] value, input int nbytes);
		int k;
		for (k = nbytes - 1; k >= 0; k--)
			file_q.push_back(value[8*k +: 8]);
	endtask

	task automatic put_word(input int unsigned addr, input logic [15:0] word);
		exp_mem[addr] = word[7:0];
		exp_mem[addr + 1] = word[15:8];
	endtask

	task automatic send_beat(input logic [7:0] index, input int unsigned ofs,
		input logic [7:0] data);
		int n;
		if (timed_out)
			return;
		// Random idle cycle on the host side
		if ($urandom % 4 == 0)
			@(negedge clk_sys);
		dl_beat.index = index;
		dl_beat.offset = ofs[loader_pkg::MEM_AW-1:0];
		dl_beat.data = data;
		dl_valid = 1'b1;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(posedge clk_sys);
			if (dl_ready)
				break;
		end
		@(negedge clk_sys);
		dl_valid = 1'b0;
		if (n >= WAIT_LIMIT) begin
			$display("Timeout: download byte at offset %h was never accepted", ofs);
			timed_out = 1'b1;
			errors++;
		end
	endtask

	task automatic compare_memory();
		int shown;
		shown = 0;
		if (mem_model.num() != exp_mem.num()) begin
			$display("FAIL mem_addr_o distinct addresses expected %h got %h",
				exp_mem.num(), mem_model.num());
			errors++;
		end
		foreach (exp_mem[a]) begin
			if (!mem_model.exists(a)) begin
				if (shown < 8)
					$display("Address %h was never written", a);
				shown++;
				errors++;
			end else if (mem_model[a] !== exp_mem[a]) begin
				if (shown < 8)
					$display("FAIL mem_data_o at %h expected %h got %h",
						a, exp_mem[a], mem_model[a]);
				shown++;
				errors++;
			end
		end
	endtask

	// ====================
	// One test case
	// ====================
	task automatic run_case(input test_case_t tc, input int num);
		loader_pkg::cart_info_t cart_exp;
		loader_pkg::crt_bank_t bank;
		logic [loader_pkg::MEM_AW-1:0] chip_addr;
		logic [15:0] end_addr;
		int unsigned exp_writes, payload, i, c, n;
		int errs_before;
		errs_before = errors;
		exp_mem.delete();
		bank_exp.delete();
		file_q.delete();
		cart_exp = '0;
		exp_writes = 0;
		if (tc.erase) begin
			// Power-on pattern repeats address bit 6
			for (i = 0; i <= 32'hFFFF; i++)
				exp_mem[i] = (i & 32'h40) ? 8'hFF : 8'h00;
			exp_writes = 32'h10000;
		end
		case (tc.kind)
			loader_pkg::KIND_PRG: begin
				file_q.push_back(tc.addr[7:0]);
				file_q.push_back(tc.addr[15:8]);
				for (i = 0; i < tc.len; i++) begin
					file_q.push_back(8'($urandom));
					exp_mem[tc.addr + i] = file_q[i + 2];
				end
				end_addr = tc.addr + tc.len;
				put_word(32'h2B, tc.addr);
				put_word(32'h2D, end_addr);
				put_word(32'h2F, end_addr);
				put_word(32'h31, end_addr);
				put_word(32'hAC, tc.addr);
				put_word(32'hAE, end_addr);
				exp_writes += tc.len + 12;
			end
			loader_pkg::KIND_CRT: begin
				for (i = 0; i < 32'h40; i++)
					file_q.push_back(8'($urandom));
				cart_exp = $urandom;
				file_q[32'h16] = cart_exp.id[15:8];
				file_q[32'h17] = cart_exp.id[7:0];
				file_q[32'h18] = cart_exp.exrom;
				file_q[32'h19] = cart_exp.game;
				chip_addr = loader_pkg::CRT_BASE;
				for (c = 0; c < tc.chips; c++) begin
					payload = tc.len + 8 * c;
					// Each chip begins on the next 8 KB boundary
					chip_addr = (chip_addr + 25'h1FFF) / 25'h2000 * 25'h2000;
					bank.bank_type = 8'($urandom);
					bank.bank_num = 16'(c);
					bank.load_addr = 16'h8000 + 16'(c * 32'h2000);
					bank.size = 16'(payload);
					bank.mem_addr = chip_addr;
					bank_exp.push_back(bank);
					push_bytes(32'h43484950, 4);
					push_bytes(payload + 16, 4);
					push_bytes({8'h00, bank.bank_type}, 2);
					push_bytes(bank.bank_num, 2);
					push_bytes(bank.load_addr, 2);
					push_bytes(bank.size, 2);
					for (i = 0; i < payload; i++) begin
						file_q.push_back(8'($urandom));
						exp_mem[chip_addr + i] = file_q[file_q.size() - 1];
					end
					chip_addr += payload;
					exp_writes += payload;
				end
			end
			default: begin
				for (i = 0; i < tc.len; i++) begin
					file_q.push_back(8'($urandom));
					exp_mem[loader_pkg::TAP_BASE + i] = file_q[i];
				end
				exp_writes += tc.len;
			end
		endcase

		mem_model.delete();
		bank_seen.delete();
		wr_count = 0;
		stall_count = 0;
		slot_pct = tc.slot_pct;
		if (tc.erase) begin
			erase_start = 1'b1;
			@(negedge clk_sys);
			erase_start = 1'b0;
			if (erase_busy !== 1'b1) begin
				$display("FAIL erase_busy_o expected 1 got %h", erase_busy);
				errors++;
			end
		end
		dl_active = 1'b1;
		for (i = 0; i < file_q.size(); i++)
			send_beat(host_index(tc.kind), i, file_q[i]);
		dl_active = 1'b0;

		if (!timed_out) begin
			for (n = 0; n < WAIT_LIMIT && (wr_count < exp_writes || erase_busy); n++)
				@(negedge clk_sys);
			if (wr_count < exp_writes || erase_busy) begin
				$display("Timeout: %0d of %0d memory writes seen, erase busy %0d",
					wr_count, exp_writes, erase_busy);
				timed_out = 1'b1;
				errors++;
			end
		end
		if (!timed_out) begin
			compare_memory();
			if (tc.kind == loader_pkg::KIND_CRT) begin
				if (cart_info !== cart_exp) begin
					$display("FAIL cart_info_o expected %h got %h", cart_exp, cart_info);
					errors++;
				end
				if (bank_seen.size() != bank_exp.size()) begin
					$display("FAIL crt_bank_valid_o strobes expected %h got %h",
						bank_exp.size(), bank_seen.size());
					errors++;
				end
				for (i = 0; i < bank_exp.size() && i < bank_seen.size(); i++) begin
					if (bank_seen[i] !== bank_exp[i]) begin
						$display("FAIL crt_bank_o[%0d] expected %h got %h",
							i, bank_exp[i], bank_seen[i]);
						errors++;
					end
				end
			end
			if (tc.slot_pct < 30 && stall_count == 0) begin
				$display("dl_ready_o never went low while memory slots were sparse");
				errors++;
			end
		end
		$display("case %0d %s addr %h len %0d erase %0d: %0d errors", num,
			kind_text(tc.kind), tc.addr, tc.len, tc.erase, errors - errs_before);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		int k, cases_run, cases_ok, errs_before;
		rnd = $urandom(seed);
		reset_n = 1'b0;
		dl_beat = '0;
		dl_valid = 1'b0;
		dl_active = 1'b0;
		erase_start = 1'b0;
		cases_run = 0;
		cases_ok = 0;
		fork
			drive_slots();
		join_none

		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		reset_n = 1'b1;
		@(posedge clk_sys);
		if (dl_ready !== 1'b0 || erase_busy !== 1'b0) begin
			$display("FAIL dl_ready_o/erase_busy_o after reset expected 0/0 got %h/%h",
				dl_ready, erase_busy);
			errors++;
		end
		// Quiet window before any stimulus
		repeat (8) @(negedge clk_sys);
		stim_started = 1'b1;

		// Kind, load address, length, chips, slot percent, erase
		add_case(loader_pkg::KIND_PRG, 16'h0801, 16'd40, 2'd0, 8'd100, 1'b0);
		add_case(loader_pkg::KIND_PRG, 16'hC000, 16'd3, 2'd0, 8'd60, 1'b0);
		add_case(loader_pkg::KIND_PRG, 16'h1000, 16'd1, 2'd0, 8'd100, 1'b0);
		add_case(loader_pkg::KIND_CRT, 16'h0000, 16'd40, 2'd2, 8'd80, 1'b0);
		add_case(loader_pkg::KIND_TAP, 16'h0000, 16'd64, 2'd0, 8'd70, 1'b0);
		add_case(loader_pkg::KIND_TAP, 16'h0000, 16'd24, 2'd0, 8'd100, 1'b1);
		add_case(loader_pkg::KIND_PRG, 16'h0801, 16'd40, 2'd0, 8'd15, 1'b0);

		for (k = 0; k < case_q.size(); k++) begin
			if (!timed_out) begin
				errs_before = errors;
				run_case(case_q[k], k);
				cases_run++;
				if (errors == errs_before)
					cases_ok++;
			end
		end

		$display("%0d of %0d cases run, %0d passed, %0d errors",
			cases_run, case_q.size(), cases_ok, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
source/loader_pkg.sv
source/load_decoder.sv
source/basic_ptr_init.sv
source/ram_erase_seq.sv
source/slot_writer.sv
source/media_loader_top.sv
test/tb_media_loader.sv

//--- Bender.yml
package:
  name: media_loader

sources:
  - files:
      - source/loader_pkg.sv
      - source/load_decoder.sv
      - source/basic_ptr_init.sv
      - source/ram_erase_seq.sv
      - source/slot_writer.sv
      - source/media_loader_top.sv
  - target: test
    files:
      - test/tb_media_loader.sv
